/* Bender.yml */
package:
  name: ddr3_read

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ddr_rd_pkg.sv
      - common/rd_fifo_if.sv
      - rtl/rstn_sync.sv
      - ddr3_read/rd_width_fifo.sv
      - ddr3_read/ddr3_read.sv
      - rtl/ddr3_read_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - test/ddr3_user_model.sv
      - test/tb_ddr3_read_top.sv

/* common/ddr_rd_defs.svh */
`ifndef DDR_RD_DEFS_SVH
`define DDR_RD_DEFS_SVH

// bus widths
`define DDR_ADDR_W       28     // word address, counted in 32-bit units
`define WORD_W           32
`define DDR_BEAT_W       256
`define WORDS_PER_BEAT   8

// one user-port request carries at most this many beats
`define DDR_MAX_BEATS    16

// read FIFO sizing, counted in 256-bit beats
`define RD_FIFO_BEATS    64
`define RD_FIFO_AE_BEATS 32     // new requests only at or below this fill

// FIFO is held clear this long after the last word of a read
`define FLUSH_CYCLES     16

`endif

/* common/ddr_rd_pkg.sv */
`default_nettype none

`include "ddr_rd_defs.svh"

package ddr_rd_pkg;

    // upstream word bus
    typedef logic [`DDR_ADDR_W-1:0] word_addr_t;   // counts 32-bit words
    typedef logic [7:0]             burst_len_t;   // words minus one, up to 256 words
    typedef logic [3:0]             rd_id_t;
    typedef logic [`WORD_W-1:0]     word_t;

    // DDR3 user port
    typedef logic [$clog2(`DDR_MAX_BEATS)-1:0] ddr_len_t;   // beats minus one
    typedef logic [`DDR_BEAT_W-1:0]            ddr_beat_t;

    // read controller
    typedef enum logic [2:0] {
        IDLE,           // waiting for an upstream address
        WAIT,           // draining FIFO, deciding on the next request
        TRANS_ADDR,     // DDR request pending
        TRANS_DATA,     // collecting the beats of the current request
        FLUSH           // FIFO held clear before the next read
    } rd_state_e;

endpackage

`default_nettype wire

/* common/rd_fifo_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface rd_fifo_if
    import ddr_rd_pkg::*;
();

    logic      flush;           // synchronous clear of both pointers
    logic      wr_en;
    ddr_beat_t wr_data;
    logic      rd_en;
    word_t     rd_data;         // word fetched by the previous rd_en
    logic      empty;
    logic      almost_empty;

    // read controller side
    modport ctrl (
        output flush,
        output wr_en,
        output wr_data,
        output rd_en,
        input  rd_data,
        input  empty,
        input  almost_empty
    );

    modport fifo (
        input  flush,
        input  wr_en,
        input  wr_data,
        input  rd_en,
        output rd_data,
        output empty,
        output almost_empty
    );

endinterface

`default_nettype wire

/* ddr3_read/ddr3_read.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rd_defs.svh"

module ddr3_read
    import ddr_rd_pkg::*;
(
    input  logic       clk,
    input  logic       ddr_rstn_sync,

    // upstream address channel
    input  rd_id_t     rd_addr_id,
    input  word_addr_t rd_addr,
    input  burst_len_t rd_addr_len,
    input  logic       rd_addr_valid,
    output logic       rd_addr_ready,

    // upstream data channel
    output rd_id_t     rd_back_id,
    output word_t      rd_data,
    output logic       rd_data_last,
    output logic       rd_data_valid,
    input  logic       rd_data_ready,

    // DDR3 user port, read request
    output word_addr_t ddr_rd_addr,
    output ddr_len_t   ddr_rd_len,
    output rd_id_t     ddr_rd_id,
    output logic       ddr_rd_addr_valid,
    input  logic       ddr_rd_addr_ready,

    // DDR3 user port, read data (no back-pressure)
    input  ddr_beat_t  ddr_rd_data,
    input  logic       ddr_rd_data_last,
    input  logic       ddr_rd_data_valid,

    rd_fifo_if.ctrl    fifo
);

    localparam int unsigned BEAT_SH = $clog2(`WORDS_PER_BEAT);    // word to beat shift
    localparam int unsigned SPAN_W  = `DDR_ADDR_W - BEAT_SH;
    localparam int unsigned LEN_W   = $bits(ddr_len_t);
    // a 256-word read starting mid-beat touches 33 beats
    localparam int unsigned BEATS_W = $clog2((1 << $bits(burst_len_t)) / `WORDS_PER_BEAT + 1);
    localparam int unsigned FLUSH_W = $clog2(`FLUSH_CYCLES);

    localparam ddr_len_t           DDR_LEN_MAX = ddr_len_t'(`DDR_MAX_BEATS - 1);
    localparam logic [FLUSH_W-1:0] FLUSH_LAST  = FLUSH_W'(`FLUSH_CYCLES - 1);

    rd_state_e state;
    rd_state_e state_nxt;

    word_addr_t         req_addr;       // next DDR request, beat aligned
    logic [BEATS_W-1:0] beats_left;     // beats still to request, minus one
    rd_id_t             id_q;
    logic [BEAT_SH-1:0] head_cnt;       // words before the requested start
    burst_len_t         word_cnt;       // words left to send, minus one
    logic               req_done;       // final DDR request has gone out
    logic               stale;          // fifo.rd_data carries nothing useful
    logic               req_valid;
    logic               addr_ready;
    logic [FLUSH_W-1:0] flush_cnt;

    word_addr_t         addr_end;
    logic [SPAN_W-1:0]  beat_span;
    logic [LEN_W:0]     req_beats;
    logic               addr_hs;
    logic               ddr_hs;
    logic               up_hs;
    logic               active;
    logic               head_need;
    logic               last_req;

    assign addr_hs = rd_addr_valid && addr_ready;
    assign ddr_hs  = req_valid && ddr_rd_addr_ready;
    assign up_hs   = rd_data_valid && rd_data_ready;

    assign active    = (state == WAIT) || (state == TRANS_ADDR) || (state == TRANS_DATA);
    assign head_need = active && (head_cnt != '0);
    assign last_req  = (beats_left <= BEATS_W'(DDR_LEN_MAX));

    // beats touched by the incoming read, minus one
    assign addr_end  = rd_addr + word_addr_t'(rd_addr_len);
    assign beat_span = addr_end[`DDR_ADDR_W-1:BEAT_SH] - rd_addr[`DDR_ADDR_W-1:BEAT_SH];

    assign req_beats = {1'b0, ddr_rd_len} + 1'b1;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (addr_hs) begin
                    state_nxt = WAIT;
                end
            end
            WAIT: begin
                if (up_hs && rd_data_last) begin
                    state_nxt = FLUSH;
                end else if (fifo.almost_empty && !req_done) begin
                    state_nxt = TRANS_ADDR;     // room for a full request
                end
            end
            TRANS_ADDR: begin
                if (ddr_hs) begin
                    state_nxt = TRANS_DATA;
                end
            end
            TRANS_DATA: begin
                if (ddr_rd_data_valid && ddr_rd_data_last) begin
                    state_nxt = WAIT;
                end
            end
            FLUSH: begin
                if (flush_cnt == FLUSH_LAST) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            state      <= IDLE;
            addr_ready <= 1'b0;
            req_valid  <= 1'b0;
        end else begin
            state      <= state_nxt;
            addr_ready <= (state_nxt == IDLE);
            // raised a cycle into TRANS_ADDR, dropped on acceptance
            req_valid  <= (state == TRANS_ADDR) && !ddr_hs;
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            req_done   <= 1'b0;
            beats_left <= '0;
        end else if (addr_hs) begin
            req_done   <= 1'b0;
            beats_left <= beat_span[BEATS_W-1:0];
        end else if (ddr_hs) begin
            if (last_req) begin
                req_done <= 1'b1;
            end else begin
                beats_left <= beats_left - BEATS_W'(req_beats);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (addr_hs) begin
            req_addr <= {rd_addr[`DDR_ADDR_W-1:BEAT_SH], {BEAT_SH{1'b0}}};
            id_q     <= rd_addr_id;
        end else if (ddr_hs && !last_req) begin
            req_addr <= req_addr + word_addr_t'({req_beats, {BEAT_SH{1'b0}}});
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            head_cnt <= '0;
        end else if (addr_hs) begin
            head_cnt <= rd_addr[BEAT_SH-1:0];
        end else if (fifo.rd_en && !stale && head_need) begin
            head_cnt <= head_cnt - 1'b1;    // one leading word dropped
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            word_cnt <= '0;
        end else if (addr_hs) begin
            word_cnt <= rd_addr_len;
        end else if (up_hs) begin
            word_cnt <= word_cnt - 1'b1;
        end
    end

    // rd_data lags rd_en by a cycle, and an empty FIFO leaves it behind
    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            stale <= 1'b1;
        end else if (state == FLUSH) begin
            stale <= 1'b1;
        end else if (fifo.empty && up_hs) begin
            stale <= 1'b1;
        end else if (fifo.rd_en && stale) begin
            stale <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            flush_cnt <= '0;
        end else if (state == FLUSH) begin
            flush_cnt <= flush_cnt + 1'b1;
        end else begin
            flush_cnt <= '0;
        end
    end

    assign rd_addr_ready = addr_ready;
    assign rd_back_id    = id_q;        // DDR3 answers in order
    assign rd_data       = fifo.rd_data;
    assign rd_data_valid = active && !stale && !head_need;
    assign rd_data_last  = active && (word_cnt == '0);

    assign ddr_rd_addr       = req_addr;
    assign ddr_rd_len        = last_req ? beats_left[LEN_W-1:0] : DDR_LEN_MAX;
    assign ddr_rd_id         = id_q;
    assign ddr_rd_addr_valid = req_valid;

    assign fifo.flush   = (state == FLUSH);
    assign fifo.wr_en   = ddr_rd_data_valid;
    assign fifo.wr_data = ddr_rd_data;
    // refill a stale output, skip head words, or advance on a transfer
    assign fifo.rd_en   = active && !fifo.empty && (head_need || stale || up_hs);

endmodule

`default_nettype wire

/* ddr3_read/rd_width_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rd_defs.svh"

module rd_width_fifo #(
    parameter int unsigned DEPTH_BEATS = `RD_FIFO_BEATS,
    parameter int unsigned AE_BEATS    = `RD_FIFO_AE_BEATS
) (
    input  logic    clk,
    input  logic    ddr_rstn_sync,
    rd_fifo_if.fifo fifo
);

    localparam int unsigned AW = $clog2(DEPTH_BEATS);       // beat index bits
    localparam int unsigned SW = $clog2(`WORDS_PER_BEAT);   // word within a beat
    localparam int unsigned CW = AW + SW + 1;               // word pointer with wrap bit

    localparam logic [CW-1:0] AE_WORDS = CW'(AE_BEATS * `WORDS_PER_BEAT);

    logic [`DDR_BEAT_W-1:0] mem [DEPTH_BEATS];

    logic [AW:0]   wr_ptr;      // in beats
    logic [CW-1:0] rd_ptr;      // in words
    logic [CW-1:0] fill;        // words currently stored
    logic [AW-1:0] rd_beat;
    logic [SW-1:0] rd_word;
    logic          wr_go;
    logic          rd_go;

    // write side works in beats, so scale it up to words
    assign fill    = {wr_ptr, {SW{1'b0}}} - rd_ptr;
    assign rd_beat = rd_ptr[CW-2:SW];
    assign rd_word = rd_ptr[SW-1:0];

    assign fifo.empty        = (fill == '0);
    assign fifo.almost_empty = (fill <= AE_WORDS);

    assign wr_go = fifo.wr_en && !fifo.flush;
    assign rd_go = fifo.rd_en && !fifo.empty && !fifo.flush;

    always_ff @(posedge clk or negedge ddr_rstn_sync) begin
        if (!ddr_rstn_sync) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (fifo.flush) begin
            // drop whatever is left of the last read
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_go) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_go) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_go) begin
            mem[wr_ptr[AW-1:0]] <= fifo.wr_data;
        end
    end

    // low word of each beat goes out first
    always_ff @(posedge clk) begin
        if (rd_go) begin
            fifo.rd_data <= mem[rd_beat][rd_word*`WORD_W +: `WORD_W];
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/ddr_rd_pkg.sv
common/rd_fifo_if.sv
rtl/rstn_sync.sv
ddr3_read/rd_width_fifo.sv
ddr3_read/ddr3_read.sv
rtl/ddr3_read_top.sv
test/ddr3_user_model.sv
test/tb_ddr3_read_top.sv

/* rtl/ddr3_read_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ddr3_read_top
    import ddr_rd_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,

    // upstream address channel
    input  rd_id_t     rd_addr_id,
    input  word_addr_t rd_addr,
    input  burst_len_t rd_addr_len,
    input  logic       rd_addr_valid,
    output logic       rd_addr_ready,

    // upstream data channel
    output rd_id_t     rd_back_id,
    output word_t      rd_data,
    output logic       rd_data_last,
    output logic       rd_data_valid,
    input  logic       rd_data_ready,

    // DDR3 user port
    output word_addr_t ddr_rd_addr,
    output ddr_len_t   ddr_rd_len,
    output rd_id_t     ddr_rd_id,
    output logic       ddr_rd_addr_valid,
    input  logic       ddr_rd_addr_ready,
    input  ddr_beat_t  ddr_rd_data,
    input  logic       ddr_rd_data_last,
    input  logic       ddr_rd_data_valid
);

    logic ddr_rstn_sync;

    rd_fifo_if fifo_if ();

    rstn_sync rstn_sync_i (
        .clk           (clk),
        .rstn          (rstn),
        .ddr_rstn_sync (ddr_rstn_sync)
    );

    ddr3_read ddr3_read_i (
        .clk               (clk),
        .ddr_rstn_sync     (ddr_rstn_sync),
        .rd_addr_id        (rd_addr_id),
        .rd_addr           (rd_addr),
        .rd_addr_len       (rd_addr_len),
        .rd_addr_valid     (rd_addr_valid),
        .rd_addr_ready     (rd_addr_ready),
        .rd_back_id        (rd_back_id),
        .rd_data           (rd_data),
        .rd_data_last      (rd_data_last),
        .rd_data_valid     (rd_data_valid),
        .rd_data_ready     (rd_data_ready),
        .ddr_rd_addr       (ddr_rd_addr),
        .ddr_rd_len        (ddr_rd_len),
        .ddr_rd_id         (ddr_rd_id),
        .ddr_rd_addr_valid (ddr_rd_addr_valid),
        .ddr_rd_addr_ready (ddr_rd_addr_ready),
        .ddr_rd_data       (ddr_rd_data),
        .ddr_rd_data_last  (ddr_rd_data_last),
        .ddr_rd_data_valid (ddr_rd_data_valid),
        .fifo              (fifo_if.ctrl)
    );

    // 256-bit beats in, 32-bit words out
    rd_width_fifo rd_width_fifo_i (
        .clk           (clk),
        .ddr_rstn_sync (ddr_rstn_sync),
        .fifo          (fifo_if.fifo)
    );

endmodule

`default_nettype wire

/* rtl/rstn_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module rstn_sync (
    input  logic clk,
    input  logic rstn,
    output logic ddr_rstn_sync
);

    logic rstn_meta;    // first stage, may go metastable on release

    // assert at once, release after two edges
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rstn_meta     <= 1'b0;
            ddr_rstn_sync <= 1'b0;
        end else begin
            rstn_meta     <= 1'b1;
            ddr_rstn_sync <= rstn_meta;
        end
    end

endmodule

`default_nettype wire

/* test/ddr3_user_model.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ddr_rd_defs.svh"

module ddr3_user_model
    import ddr_rd_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  word_addr_t ddr_rd_addr,
    input  ddr_len_t   ddr_rd_len,
    input  rd_id_t     ddr_rd_id,
    input  logic       ddr_rd_addr_valid,
    output logic       ddr_rd_addr_ready,
    output ddr_beat_t  ddr_rd_data,
    output logic       ddr_rd_data_last,
    output logic       ddr_rd_data_valid
);

    word_addr_t  req_addr;
    ddr_len_t    req_len;
    int unsigned req_count;     // requests accepted so far

    // every word carries its own word address, scrambled in the upper half
    function automatic ddr_beat_t fill_beat(input word_addr_t base);
        ddr_beat_t beat;
        for (int k = 0; k < `WORDS_PER_BEAT; k++) begin
            beat[k*`WORD_W +: `WORD_W] = word_t'(base + word_addr_t'(k)) ^ 32'h5a5a_0000;
        end
        return beat;
    endfunction

    initial begin
        ddr_rd_addr_ready = 1'b0;
        ddr_rd_data       = '0;
        ddr_rd_data_last  = 1'b0;
        ddr_rd_data_valid = 1'b0;
        req_count         = 0;
        forever begin
            @(posedge clk);
            if (rstn && ddr_rd_addr_valid) begin
                repeat ($urandom % 4) @(posedge clk);
                ddr_rd_addr_ready <= 1'b1;
                @(posedge clk);     // request holds, so it is taken here
                req_addr = ddr_rd_addr;
                req_len  = ddr_rd_len;
                ddr_rd_addr_ready <= 1'b0;
                req_count = req_count + 1;
                $display("ddr request %0d: addr %h beats %0d id %h",
                         req_count, req_addr, int'(req_len) + 1, ddr_rd_id);
                // read latency of 1 to 6 cycles
                repeat ($urandom % 6) @(posedge clk);
                for (int b = 0; b <= int'(req_len); b++) begin
                    ddr_rd_data_valid <= 1'b1;
                    ddr_rd_data       <= fill_beat(req_addr + word_addr_t'(b * `WORDS_PER_BEAT));
                    ddr_rd_data_last  <= (b == int'(req_len));
                    @(posedge clk);
                end
                ddr_rd_data_valid <= 1'b0;
                ddr_rd_data_last  <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_ddr3_read_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ddr3_read_top
    import ddr_rd_pkg::*;
();

    localparam int NUM_READS = 28;

    logic       clk;
    logic       rstn;
    rd_id_t     rd_addr_id;
    word_addr_t rd_addr;
    burst_len_t rd_addr_len;
    logic       rd_addr_valid;
    logic       rd_addr_ready;
    rd_id_t     rd_back_id;
    word_t      rd_data;
    logic       rd_data_last;
    logic       rd_data_valid;
    logic       rd_data_ready;
    word_addr_t ddr_rd_addr;
    ddr_len_t   ddr_rd_len;
    rd_id_t     ddr_rd_id;
    logic       ddr_rd_addr_valid;
    logic       ddr_rd_addr_ready;
    ddr_beat_t  ddr_rd_data;
    logic       ddr_rd_data_last;
    logic       ddr_rd_data_valid;

    string      test_name;
    rd_id_t     cur_id;
    word_addr_t cur_addr;
    burst_len_t cur_len;
    word_addr_t next_req_addr;      // where the next DDR request must start
    int         words_seen;
    int         req_beats_seen;
    int         exp_beats;
    logic       busy;               // a read is accepted and not yet finished
    logic       rand_ready;
    word_t      exp_word;

    ddr3_read_top dut_i (.*);

    ddr3_user_model model_i (.*);

    task automatic flag_mismatch(input string what, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
        $display("ERROR %s: %s expected %h actual %h", test_name, what, exp_val, act_val);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string what);
        $display("%s: %s", test_name, what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // word and last held while the master stalls
    assert property (@(posedge clk) disable iff (!rstn)
        rd_data_valid && !rd_data_ready |=>
            rd_data_valid && $stable(rd_data) && $stable(rd_data_last))
        else abort_run("rd_data or rd_data_last moved while the master stalled");
    assert property (@(posedge clk) disable iff (!rstn) rd_data_valid |-> busy)
        else abort_run("rd_data_valid high outside a read");
    assert property (@(posedge clk) disable iff (!rstn) rd_data_valid |-> rd_back_id == cur_id)
        else flag_mismatch("rd_back_id", 32'($sampled(cur_id)), 32'($sampled(rd_back_id)));
    assert property (@(posedge clk) disable iff (!rstn)
        ddr_rd_addr_valid |-> ddr_rd_addr[2:0] == 3'd0)
        else flag_mismatch("ddr_rd_addr[2:0]", 32'd0, 32'($sampled(ddr_rd_addr[2:0])));
    assert property (@(posedge clk) disable iff (!rstn)
        ddr_rd_addr_valid |-> ddr_rd_id == cur_id)
        else flag_mismatch("ddr_rd_id", 32'($sampled(cur_id)), 32'($sampled(ddr_rd_id)));
    assert property (@(posedge clk) disable iff (!rstn)
        ddr_rd_addr_valid && !ddr_rd_addr_ready |=>
            ddr_rd_addr_valid && $stable(ddr_rd_addr) && $stable(ddr_rd_len))
        else abort_run("DDR request dropped or changed before it was accepted");

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rd_data_ready = 1'b0;
        forever begin
            @(posedge clk);
            rd_data_ready <= rand_ready ? (($urandom % 3) != 0) : 1'b1;
        end
    end

    // DDR request chain against the read in flight
    always @(posedge clk) begin
        if (rstn && ddr_rd_addr_valid && ddr_rd_addr_ready) begin
            assert (ddr_rd_addr == next_req_addr)
                else flag_mismatch("ddr_rd_addr", 32'(next_req_addr), 32'(ddr_rd_addr));
            next_req_addr  = next_req_addr + word_addr_t'((int'(ddr_rd_len) + 1) * 8);
            req_beats_seen = req_beats_seen + int'(ddr_rd_len) + 1;
            assert (req_beats_seen <= exp_beats)
                else flag_mismatch("requested beats", exp_beats, req_beats_seen);
        end
    end

    // upstream words against the pattern
    always @(posedge clk) begin
        if (rstn && rd_data_valid && rd_data_ready) begin
            exp_word = word_t'(cur_addr + word_addr_t'(words_seen)) ^ 32'h5a5a_0000;
            assert (rd_data == exp_word)
                else flag_mismatch("rd_data", exp_word, rd_data);
            assert (rd_data_last == (words_seen == int'(cur_len)))
                else flag_mismatch("rd_data_last", words_seen == int'(cur_len), rd_data_last);
            if (words_seen == int'(cur_len)) begin
                busy <= 1'b0;
            end
            words_seen = words_seen + 1;
        end
    end

    task automatic run_read(input rd_id_t id, input word_addr_t addr, input burst_len_t len);
        word_addr_t last_addr;
        last_addr      = addr + word_addr_t'(len);
        cur_id         = id;
        cur_addr       = addr;
        cur_len        = len;
        words_seen     = 0;
        req_beats_seen = 0;
        next_req_addr  = {addr[27:3], 3'b000};
        exp_beats      = int'(last_addr[27:3]) - int'(addr[27:3]) + 1;
        rd_addr_id    <= id;
        rd_addr       <= addr;
        rd_addr_len   <= len;
        rd_addr_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!rd_addr_ready);
        rd_addr_valid <= 1'b0;
        busy = 1'b1;
        while (busy) @(posedge clk);
        assert (req_beats_seen == exp_beats)
            else flag_mismatch("requested beats", exp_beats, req_beats_seen);
    endtask

    initial begin
        void'($urandom(32'hd99f_5d66));
        rstn          = 1'b0;
        rd_addr_id    = '0;
        rd_addr       = '0;
        rd_addr_len   = '0;
        rd_addr_valid = 1'b0;
        busy          = 1'b0;
        rand_ready    = 1'b0;
        cur_id        = '0;
        test_name     = "reset_state";
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        do begin
            @(posedge clk);
        end while (!rd_addr_ready);
        assert (!ddr_rd_addr_valid && !rd_data_valid && !rd_data_last)
            else abort_run("a request or data output is active after reset");

        test_name = "aligned_read";
        run_read(4'h3, 28'h000_0100, 8'd7);

        test_name = "unaligned_read";
        run_read(4'h5, 28'h000_0203, 8'd20);
        run_read(4'h9, 28'h000_0417, 8'd40);

        test_name = "request_split";
        run_read(4'ha, 28'h001_0000, 8'd255);
        run_read(4'hc, 28'h002_0005, 8'd255);

        test_name  = "back_pressure";
        rand_ready <= 1'b1;
        run_read(4'h1, 28'h003_0002, 8'd63);
        run_read(4'h2, 28'h003_1000, 8'd255);
        run_read(4'h6, 28'h003_2007, 8'd0);

        test_name = "back_to_back";
        for (int i = 0; i < 20; i++) begin
            rand_ready <= (i % 2) == 1;
            run_read(rd_id_t'($urandom), word_addr_t'($urandom % 32'h0100_0000),
                     burst_len_t'($urandom));
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

    // each read is far shorter than this allowance
    initial begin
        repeat (NUM_READS * 4000) @(posedge clk);
        $display("watchdog expired before all reads completed");
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire
